//--- flist.f
hw/chdr_framer_pkg.sv
hw/pkt_pair_admit.sv
hw/stream_fifo.sv
hw/chdr_hdr_framer.sv
hw/chdr_pkt_gate.sv
hw/chdr_framer_top.sv
tests/tb_chdr_framer.sv

//--- tests/tb_chdr_framer.sv
// Directed testbench for the CHDR framer top level; compile with flist.f and elaborate tb_chdr_framer
`timescale 1ns/1ps
`default_nettype none

module tb_chdr_framer
  import chdr_framer_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;  // Cycles per wait before giving up

  logic        axis_chdr_clk = 1'b0;
  logic        axis_chdr_rst;
  chdr_word_t  i_ctxt_tdata;
  ctxt_field_t i_ctxt_tuser;
  logic        i_ctxt_tlast, i_ctxt_tvalid, o_ctxt_tready;
  chdr_word_t  i_pyld_tdata;
  logic        i_pyld_tlast, i_pyld_tvalid, o_pyld_tready;
  chdr_word_t  o_chdr_tdata;
  logic        o_chdr_tlast, o_chdr_tvalid, i_chdr_tready;
  err_count_t  o_framer_errors;

  logic [31:0] lfsr_state = 32'hf47ab651;
  chdr_word_t  exp_words[$];     // Expected output words in order
  logic        exp_lasts[$];
  err_count_t  exp_errors;       // Expected drop count
  chdr_word_t  ctxt_words[$];    // Staged stimulus for the next pair
  ctxt_field_t ctxt_fields[$];
  chdr_word_t  pyld_words[$];
  logic        collect_done;

  chdr_framer_top #(
    .PREFETCH_EN(1), .CTXT_FIFO_LOG2(2), .PYLD_FIFO_LOG2(2), .MTU_LOG2(5)
  ) UUT (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_ctxt_tdata, .i_ctxt_tuser, .i_ctxt_tlast, .i_ctxt_tvalid, .o_ctxt_tready,
    .i_pyld_tdata, .i_pyld_tlast, .i_pyld_tvalid, .o_pyld_tready,
    .o_chdr_tdata, .o_chdr_tlast, .o_chdr_tvalid, .i_chdr_tready,
    .o_framer_errors
  );

  always #5 axis_chdr_clk = ~axis_chdr_clk;  // 10 ns period

  // ------------------------------------------------------------------------
  // Random bits, error stop and compare tasks
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
  endfunction

  task automatic take_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic rand_word(output chdr_word_t w);
    logic b;
    int   i;
    for (i = 0; i < CHDR_W; i++) begin
      take_bit(b);  // One step per bit
      w[i] = b;
    end
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input string name, input chdr_word_t got, input chdr_word_t exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic compare_last(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic compare_count(input string name, input err_count_t got, input err_count_t exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
                              $time, name, got, exp));
  endtask

  // ------------------------------------------------------------------------
  // Stimulus staging and expected output
  // ------------------------------------------------------------------------
  task automatic stage_ctxt(input int n_md, input ctxt_field_t hdr_field, input int n_extra);
    chdr_word_t w;
    int         i;
    ctxt_words.delete();
    ctxt_fields.delete();
    rand_word(w);
    w[52:48] = n_md[4:0];  // NumMData in the header
    ctxt_words.push_back(w);
    ctxt_fields.push_back(hdr_field);
    for (i = 0; i < n_extra; i++) begin
      rand_word(w);
      ctxt_words.push_back(w);
      ctxt_fields.push_back(FIELD_MDATA);
    end
  endtask

  task automatic stage_pyld(input int n);
    chdr_word_t w;
    int         i;
    pyld_words.delete();
    for (i = 0; i < n; i++) begin
      rand_word(w);
      pyld_words.push_back(w);
    end
  endtask

  // Context is good with an HDR_TS header and NumMData MDATA words behind it
  task automatic add_expected(input chdr_word_t cw[$], input ctxt_field_t cf[$],
                              input chdr_word_t pw[$], output int n_words);
    int   n_md, i;
    logic good;
    n_md = int'(cw[0][52:48]);
    good = (cf[0] == FIELD_HDR_TS) && (cw.size() == n_md + 1);
    for (i = 1; i < cw.size(); i++)
      if (cf[i] != FIELD_MDATA) good = 1'b0;
    n_words = 0;
    if (good) begin
      foreach (cw[j]) begin
        exp_words.push_back(cw[j]);
        exp_lasts.push_back(1'b0);  // Context words never end the packet
      end
      foreach (pw[j]) begin
        exp_words.push_back(pw[j]);
        exp_lasts.push_back(j == pw.size() - 1);
      end
      n_words = cw.size() + pw.size();
    end else begin
      exp_errors = exp_errors + 1'b1;  // Dropped pair shows up as one error beat
    end
  endtask

  // ------------------------------------------------------------------------
  // Drivers and collector
  // ------------------------------------------------------------------------
  task automatic send_ctxt(input chdr_word_t words[$], input ctxt_field_t fields[$]);
    int i, n;
    for (i = 0; i < words.size(); i++) begin
      i_ctxt_tdata  <= words[i];
      i_ctxt_tuser  <= fields[i];
      i_ctxt_tlast  <= (i == words.size() - 1);
      i_ctxt_tvalid <= 1'b1;
      n = 0;
      do begin
        @(posedge axis_chdr_clk);
        n++;
      end while (!o_ctxt_tready && n < WAIT_LIMIT);
      if (!o_ctxt_tready)
        stop_on_error("context input was never accepted within the timeout");
    end
    i_ctxt_tvalid <= 1'b0;
    i_ctxt_tlast  <= 1'b0;
  endtask

  task automatic send_pyld(input chdr_word_t words[$]);
    int i, n;
    for (i = 0; i < words.size(); i++) begin
      i_pyld_tdata  <= words[i];
      i_pyld_tlast  <= (i == words.size() - 1);
      i_pyld_tvalid <= 1'b1;
      n = 0;
      do begin
        @(posedge axis_chdr_clk);
        n++;
      end while (!o_pyld_tready && n < WAIT_LIMIT);
      if (!o_pyld_tready)
        stop_on_error("payload input was never accepted within the timeout");
    end
    i_pyld_tvalid <= 1'b0;
    i_pyld_tlast  <= 1'b0;
  endtask

  task automatic collect(input int n_words);
    chdr_word_t w;
    logic       l;
    int         i, n;
    for (i = 0; i < n_words; i++) begin
      w = exp_words.pop_front();
      l = exp_lasts.pop_front();
      n = 0;
      do begin
        @(posedge axis_chdr_clk);  // Pre-edge values are the transferred ones
        n++;
      end while (!(o_chdr_tvalid && i_chdr_tready) && n < WAIT_LIMIT);
      if (!(o_chdr_tvalid && i_chdr_tready))
        stop_on_error("no CHDR output word arrived within the timeout");
      compare_word("o_chdr_tdata", o_chdr_tdata, w);
      compare_last("o_chdr_tlast", o_chdr_tlast, l);
    end
  endtask

  task automatic run_pair();
    int n_words;
    add_expected(ctxt_words, ctxt_fields, pyld_words, n_words);
    fork
      send_ctxt(ctxt_words, ctxt_fields);
      send_pyld(pyld_words);
      collect(n_words);
    join
  endtask

  // ------------------------------------------------------------------------
  // Behaviors
  // ------------------------------------------------------------------------
  task automatic header_only_pair();
    stage_ctxt(0, FIELD_HDR_TS, 0);  // Header alone with last set
    stage_pyld(3);
    run_pair();
    compare_count("o_framer_errors", o_framer_errors, exp_errors);
  endtask

  task automatic two_mdata_pair();
    stage_ctxt(2, FIELD_HDR_TS, 2);
    stage_pyld(2);
    run_pair();
    compare_count("o_framer_errors", o_framer_errors, exp_errors);
  endtask

  task automatic bad_header_field_drop();
    stage_ctxt(0, FIELD_MDATA, 0);   // Wrong tag on the header
    stage_pyld(2);
    run_pair();
    stage_ctxt(1, FIELD_HDR_TS, 1);  // Good pair behind it
    stage_pyld(3);
    run_pair();
    compare_count("o_framer_errors", o_framer_errors, exp_errors);
  endtask

  task automatic early_last_drop();
    stage_ctxt(2, FIELD_HDR_TS, 0);  // Count of two but last on the header
    stage_pyld(2);
    run_pair();
    stage_ctxt(0, FIELD_HDR_TS, 0);
    stage_pyld(4);
    run_pair();
    compare_count("o_framer_errors", o_framer_errors, exp_errors);
  endtask

  task automatic prefetch_with_stalls();
    chdr_word_t  a_cw[$], a_pw[$];
    ctxt_field_t a_cf[$];
    int          n_a, n_b, n;
    logic        b;
    stage_ctxt(1, FIELD_HDR_TS, 1);
    stage_pyld(4);
    add_expected(ctxt_words, ctxt_fields, pyld_words, n_a);
    a_cw = ctxt_words;
    a_cf = ctxt_fields;
    a_pw = pyld_words;
    stage_ctxt(0, FIELD_HDR_TS, 0);
    stage_pyld(3);
    add_expected(ctxt_words, ctxt_fields, pyld_words, n_b);
    collect_done = 1'b0;
    fork
      begin
        send_ctxt(a_cw, a_cf);               // Second context is the prefetch
        send_ctxt(ctxt_words, ctxt_fields);
        send_pyld(a_pw);
        send_pyld(pyld_words);
      end
      begin
        collect(n_a + n_b);
        collect_done = 1'b1;
      end
      begin
        n = 0;
        while (!collect_done && n < WAIT_LIMIT * 4) begin
          @(posedge axis_chdr_clk);
          take_bit(b);
          i_chdr_tready <= b;                // Random output stalls
          n++;
        end
      end
    join
    i_chdr_tready <= 1'b1;
    compare_count("o_framer_errors", o_framer_errors, exp_errors);
  endtask

  initial begin
    axis_chdr_rst <= 1'b1;
    i_ctxt_tdata  <= '0;
    i_ctxt_tuser  <= FIELD_HDR;
    i_ctxt_tlast  <= 1'b0;
    i_ctxt_tvalid <= 1'b0;
    i_pyld_tdata  <= '0;
    i_pyld_tlast  <= 1'b0;
    i_pyld_tvalid <= 1'b0;
    i_chdr_tready <= 1'b1;
    exp_errors    = '0;
    collect_done  = 1'b0;
    repeat (16) @(posedge axis_chdr_clk);
    axis_chdr_rst <= 1'b0;
    @(posedge axis_chdr_clk);
    compare_last("o_chdr_tvalid", o_chdr_tvalid, 1'b0);  // Idle after reset
    compare_count("o_framer_errors", o_framer_errors, exp_errors);
    header_only_pair();
    two_mdata_pair();
    bad_header_field_drop();
    early_last_drop();
    prefetch_with_stalls();
    @(posedge axis_chdr_clk);  // Gate holds nothing more once the last packet is read
    if (o_chdr_tvalid === 1'b0) begin
      $display("Test passed");
      $finish;
    end else begin
      stop_on_error("CHDR output still valid after the last expected word");
    end
  end

endmodule

`default_nettype wire

//--- hw/chdr_framer_top.sv
// CHDR data-packet framer top level; joins a context and a payload stream into CHDR packets
`timescale 1ns/1ps
`default_nettype none

module chdr_framer_top
  import chdr_framer_pkg::*;
#(
  parameter int PREFETCH_EN    = 1,
  parameter int CTXT_FIFO_LOG2 = 2,
  parameter int PYLD_FIFO_LOG2 = 2,
  parameter int MTU_LOG2       = 10
) (
  input  wire         axis_chdr_clk,
  input  wire         axis_chdr_rst,
  // Context input
  input  chdr_word_t  i_ctxt_tdata,
  input  ctxt_field_t i_ctxt_tuser,
  input  wire         i_ctxt_tlast,
  input  wire         i_ctxt_tvalid,
  output logic        o_ctxt_tready,
  // Payload input
  input  chdr_word_t  i_pyld_tdata,
  input  wire         i_pyld_tlast,
  input  wire         i_pyld_tvalid,
  output logic        o_pyld_tready,
  // CHDR output
  output chdr_word_t  o_chdr_tdata,
  output logic        o_chdr_tlast,
  output logic        o_chdr_tvalid,
  input  wire         i_chdr_tready,
  // Status
  output err_count_t  o_framer_errors
);

  // FIFO write and read sides
  ctxt_beat_t ctxt_in_beat, ctxt_out_beat;
  pyld_beat_t pyld_in_beat, pyld_out_beat;
  logic       ctxt_in_valid, ctxt_in_ready, ctxt_out_valid, ctxt_out_ready;
  logic       pyld_in_valid, pyld_in_ready, pyld_out_valid, pyld_out_ready;
  // Framer to gate
  chdr_word_t fr_word;
  logic       fr_last, fr_error, fr_valid, fr_ready;

  assign ctxt_in_beat = '{last: i_ctxt_tlast, field: i_ctxt_tuser, word: i_ctxt_tdata};
  assign pyld_in_beat = '{last: i_pyld_tlast, word: i_pyld_tdata};

  pkt_pair_admit #(.PREFETCH_EN(PREFETCH_EN)) admit_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_ctxt_tvalid, .i_ctxt_tlast, .i_ctxt_fifo_tready(ctxt_in_ready),
    .o_ctxt_fifo_tvalid(ctxt_in_valid), .o_ctxt_tready,
    .i_pyld_tvalid, .i_pyld_tlast, .i_pyld_fifo_tready(pyld_in_ready),
    .o_pyld_fifo_tvalid(pyld_in_valid), .o_pyld_tready
  );

  stream_fifo #(.beat_t(ctxt_beat_t), .DEPTH_LOG2(CTXT_FIFO_LOG2)) ctxt_fifo_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_beat(ctxt_in_beat), .i_valid(ctxt_in_valid), .o_ready(ctxt_in_ready),
    .o_beat(ctxt_out_beat), .o_valid(ctxt_out_valid), .i_ready(ctxt_out_ready)
  );

  stream_fifo #(.beat_t(pyld_beat_t), .DEPTH_LOG2(PYLD_FIFO_LOG2)) pyld_fifo_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_beat(pyld_in_beat), .i_valid(pyld_in_valid), .o_ready(pyld_in_ready),
    .o_beat(pyld_out_beat), .o_valid(pyld_out_valid), .i_ready(pyld_out_ready)
  );

  chdr_hdr_framer framer_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_ctxt_beat(ctxt_out_beat), .i_ctxt_valid(ctxt_out_valid), .o_ctxt_ready(ctxt_out_ready),
    .i_pyld_beat(pyld_out_beat), .i_pyld_valid(pyld_out_valid), .o_pyld_ready(pyld_out_ready),
    .o_word(fr_word), .o_last(fr_last), .o_error(fr_error), .o_valid(fr_valid),
    .i_ready(fr_ready), .o_framer_errors
  );

  chdr_pkt_gate #(.MTU_LOG2(MTU_LOG2)) gate_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_word(fr_word), .i_last(fr_last), .i_error(fr_error), .i_valid(fr_valid),
    .o_ready(fr_ready),
    .o_chdr_tdata, .o_chdr_tlast, .o_chdr_tvalid, .i_chdr_tready
  );

endmodule

`default_nettype wire

//--- hw/chdr_pkt_gate.sv
// Store-and-forward CHDR packet gate; releases whole packets and discards ones ended by an error
`timescale 1ns/1ps
`default_nettype none

module chdr_pkt_gate
  import chdr_framer_pkg::*;
#(
  parameter int MTU_LOG2 = 10   // Buffer holds 2**MTU_LOG2 words
) (
  input  wire        axis_chdr_clk,
  input  wire        axis_chdr_rst,
  // From framer
  input  chdr_word_t i_word,
  input  wire        i_last,
  input  wire        i_error,
  input  wire        i_valid,
  output logic       o_ready,
  // CHDR output
  output chdr_word_t o_chdr_tdata,
  output logic       o_chdr_tlast,
  output logic       o_chdr_tvalid,
  input  wire        i_chdr_tready
);

  localparam logic [MTU_LOG2:0] DEPTH_CNT = {1'b1, {MTU_LOG2{1'b0}}};

  pyld_beat_t          buf_mem [0:(1 << MTU_LOG2)-1];  // Word plus its tlast
  logic [MTU_LOG2:0]   wr_ptr, cmt_ptr, rd_ptr;        // Extra MSB tells full from empty
  logic [MTU_LOG2:0]   pkt_len;                        // Words of the open packet
  logic                full, in_xfer, out_xfer;

  assign pkt_len  = wr_ptr - cmt_ptr;
  assign full     = ((wr_ptr - rd_ptr) == DEPTH_CNT);
  assign o_ready  = !full || i_error;  // Error beat is never stored
  assign in_xfer  = i_valid && o_ready;
  assign out_xfer = o_chdr_tvalid && i_chdr_tready;

  // Only committed words are visible to the reader
  assign o_chdr_tvalid = (rd_ptr != cmt_ptr);
  assign o_chdr_tdata  = buf_mem[rd_ptr[MTU_LOG2-1:0]].word;
  assign o_chdr_tlast  = buf_mem[rd_ptr[MTU_LOG2-1:0]].last;

  always_ff @(posedge axis_chdr_clk) begin
    if (in_xfer && !i_error)
      buf_mem[wr_ptr[MTU_LOG2-1:0]] <= '{last: i_last, word: i_word};
  end

  // --------------------------------------------------------------------------
  // Write, commit and read pointers
  // --------------------------------------------------------------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      wr_ptr  <= '0;
      cmt_ptr <= '0;
      rd_ptr  <= '0;
    end else begin
      if (in_xfer) begin
        if (i_error) begin
          wr_ptr <= cmt_ptr;                // Rewind, partial packet is gone
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
          if (i_last)
            cmt_ptr <= wr_ptr + 1'b1;       // Packet complete, release to reader
        end
      end
      if (out_xfer)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // A packet that fills the whole buffer without last can never be released
  a_pkt_fits : assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (i_valid && !i_error) |-> (pkt_len < DEPTH_CNT))
    else $error("packet longer than gate buffer of %0d words", DEPTH_CNT);

endmodule

`default_nettype wire

//--- hw/chdr_hdr_framer.sv
// CHDR framer FSM; checks context packets, merges header, metadata and payload into one stream
`timescale 1ns/1ps
`default_nettype none

module chdr_hdr_framer
  import chdr_framer_pkg::*;
(
  input  wire        axis_chdr_clk,
  input  wire        axis_chdr_rst,
  // Context FIFO read side
  input  ctxt_beat_t i_ctxt_beat,
  input  wire        i_ctxt_valid,
  output logic       o_ctxt_ready,
  // Payload FIFO read side
  input  pyld_beat_t i_pyld_beat,
  input  wire        i_pyld_valid,
  output logic       o_pyld_ready,
  // To packet gate
  output chdr_word_t o_word,
  output logic       o_last,
  output logic       o_error,
  output logic       o_valid,
  input  wire        i_ready,
  // Status
  output err_count_t o_framer_errors
);

  typedef enum logic [2:0] {
    ST_HDR       = 3'd0,  // Header word, carries the timestamp
    ST_MDATA     = 3'd1,  // Metadata words
    ST_BODY      = 3'd2,  // Payload words
    ST_DROP_CTXT = 3'd3,  // Discard rest of a bad context packet
    ST_DROP_PYLD = 3'd4,  // Discard the matching payload packet
    ST_TERMINATE = 3'd5   // Error beat to flush the partial packet
  } state_t;

  state_t     state;
  num_mdata_t mdata_pending;  // Metadata words still expected
  num_mdata_t hdr_mdata;
  logic       ctxt_xfer, pyld_xfer;

  assign hdr_mdata = chdr_get_num_mdata(i_ctxt_beat.word);
  assign ctxt_xfer = i_ctxt_valid && o_ctxt_ready;
  assign pyld_xfer = i_pyld_valid && o_pyld_ready;

  // --------------------------------------------------------------------------
  // State register and error count
  // --------------------------------------------------------------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      state           <= ST_HDR;
      mdata_pending   <= '0;
      o_framer_errors <= '0;
    end else begin
      case (state)
        ST_HDR: if (ctxt_xfer) begin
          mdata_pending <= hdr_mdata;
          if (hdr_mdata != '0) begin
            if (i_ctxt_beat.last)
              state <= ST_DROP_PYLD;                  // Header ends early
            else if (i_ctxt_beat.field == FIELD_HDR_TS)
              state <= ST_MDATA;
            else
              state <= ST_DROP_CTXT;                  // Bad tag, more context follows
          end else begin
            if (!i_ctxt_beat.last)
              state <= ST_DROP_CTXT;                  // Extra context words
            else if (i_ctxt_beat.field == FIELD_HDR_TS)
              state <= ST_BODY;
            else
              state <= ST_DROP_PYLD;
          end
        end
        ST_MDATA: if (ctxt_xfer) begin
          mdata_pending <= mdata_pending - 1'b1;
          if (mdata_pending != 5'd1) begin
            if (i_ctxt_beat.last)
              state <= ST_DROP_PYLD;                  // Context ended before the count
            else if (i_ctxt_beat.field != FIELD_MDATA)
              state <= ST_DROP_CTXT;
          end else begin
            // Final counted word must carry last
            if (!i_ctxt_beat.last)
              state <= ST_DROP_CTXT;
            else if (i_ctxt_beat.field == FIELD_MDATA)
              state <= ST_BODY;
            else
              state <= ST_DROP_PYLD;
          end
        end
        ST_BODY:      if (pyld_xfer && i_pyld_beat.last) state <= ST_HDR;
        ST_DROP_CTXT: if (ctxt_xfer && i_ctxt_beat.last) state <= ST_DROP_PYLD;
        ST_DROP_PYLD: if (pyld_xfer && i_pyld_beat.last) state <= ST_TERMINATE;
        ST_TERMINATE: if (i_ready) begin
          state           <= ST_HDR;
          o_framer_errors <= o_framer_errors + 1'b1;  // Counted when the gate takes it
        end
        default: state <= ST_HDR;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Output routing, combinational from the FIFO heads
  // --------------------------------------------------------------------------
  always_comb begin
    o_valid      = 1'b0;
    o_last       = 1'b0;
    o_ctxt_ready = 1'b0;
    o_pyld_ready = 1'b0;
    case (state)
      ST_HDR, ST_MDATA: begin
        o_valid      = i_ctxt_valid;   // Context words never end the output packet
        o_ctxt_ready = i_ready;
      end
      ST_BODY: begin
        o_valid      = i_pyld_valid;
        o_last       = i_pyld_beat.last;
        o_pyld_ready = i_ready;
      end
      ST_DROP_CTXT: o_ctxt_ready = 1'b1;  // Sink without forwarding
      ST_DROP_PYLD: o_pyld_ready = 1'b1;
      ST_TERMINATE: begin
        o_valid = 1'b1;
        o_last  = 1'b1;
      end
      default: ;
    endcase
  end

  assign o_word  = (state == ST_BODY) ? i_pyld_beat.word : i_ctxt_beat.word;
  assign o_error = (state == ST_TERMINATE);

  a_state_legal : assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    state inside {ST_HDR, ST_MDATA, ST_BODY, ST_DROP_CTXT, ST_DROP_PYLD, ST_TERMINATE})
    else $error("framer in illegal state %0d", state);

endmodule

`default_nettype wire

//--- hw/stream_fifo.sv
// Single-clock valid/ready FIFO for any packed beat type; one instance per input stream
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type beat_t     = logic [7:0],
  parameter int  DEPTH_LOG2 = 2
) (
  input  wire   axis_chdr_clk,
  input  wire   axis_chdr_rst,
  // Write side
  input  beat_t i_beat,
  input  wire   i_valid,
  output logic  o_ready,
  // Read side
  output beat_t o_beat,
  output logic  o_valid,
  input  wire   i_ready
);

  // Occupancy when full, one bit wider than the pointers
  localparam logic [DEPTH_LOG2:0] FULL_CNT = {1'b1, {DEPTH_LOG2{1'b0}}};

  beat_t                mem [0:(1 << DEPTH_LOG2)-1];
  logic [DEPTH_LOG2-1:0] wr_ptr, rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  wr_en, rd_en;

  assign o_ready = (count != FULL_CNT);  // Low only when full
  assign o_valid = (count != '0);
  assign o_beat  = mem[rd_ptr];          // Head entry, readable the cycle after the write

  assign wr_en = i_valid && o_ready;
  assign rd_en = o_valid && i_ready;

  // Storage
  always_ff @(posedge axis_chdr_clk) begin
    if (wr_en)
      mem[wr_ptr] <= i_beat;
  end

  // Pointers and occupancy
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or simultaneous write and read
      endcase
    end
  end

  a_count_range : assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    count <= FULL_CNT)
    else $error("FIFO occupancy %0d above depth", count);

endmodule

`default_nettype wire

//--- hw/pkt_pair_admit.sv
// Admission control in front of the FIFOs; lets each payload packet in only behind its context
`timescale 1ns/1ps
`default_nettype none

module pkt_pair_admit #(
  parameter int PREFETCH_EN = 1   // Allow one extra context packet ahead
) (
  input  wire  axis_chdr_clk,
  input  wire  axis_chdr_rst,
  // Context side
  input  wire  i_ctxt_tvalid,
  input  wire  i_ctxt_tlast,
  input  wire  i_ctxt_fifo_tready,
  output logic o_ctxt_fifo_tvalid,
  output logic o_ctxt_tready,
  // Payload side
  input  wire  i_pyld_tvalid,
  input  wire  i_pyld_tlast,
  input  wire  i_pyld_fifo_tready,
  output logic o_pyld_fifo_tvalid,
  output logic o_pyld_tready
);

  logic [2:0] ctxt_pkt_cnt, pyld_pkt_cnt;
  logic [2:0] pkt_diff;  // Context packets ahead of payload, wraps with the counts
  logic       pass_ctxt, pass_pyld;

  assign pkt_diff  = ctxt_pkt_cnt - pyld_pkt_cnt;
  assign pass_pyld = (pkt_diff > 3'd0);  // Needs a context packet in front
  assign pass_ctxt = (pkt_diff < ((PREFETCH_EN == 1) ? 3'd2 : 3'd1));

  // Pass conditions go into both directions of each handshake
  assign o_ctxt_fifo_tvalid = i_ctxt_tvalid && pass_ctxt;
  assign o_ctxt_tready      = i_ctxt_fifo_tready && pass_ctxt;
  assign o_pyld_fifo_tvalid = i_pyld_tvalid && pass_pyld;
  assign o_pyld_tready      = i_pyld_fifo_tready && pass_pyld;

  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      ctxt_pkt_cnt <= 3'd0;
      pyld_pkt_cnt <= 3'd0;
    end else begin
      if (i_ctxt_tvalid && o_ctxt_tready && i_ctxt_tlast)
        ctxt_pkt_cnt <= ctxt_pkt_cnt + 3'd1;  // Count on last beat only
      if (i_pyld_tvalid && o_pyld_tready && i_pyld_tlast)
        pyld_pkt_cnt <= pyld_pkt_cnt + 3'd1;
    end
  end

  // Payload can never overtake context, prefetch never runs more than one deep
  a_pair_diff : assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    pkt_diff <= 3'd2)
    else $error("context/payload packet difference out of range: %0d", pkt_diff);

endmodule

`default_nettype wire

//--- hw/chdr_framer_pkg.sv
// Shared CHDR framer types, context field codes and header helpers; import into RTL and testbench
`default_nettype none

package chdr_framer_pkg;

  // --------------------------------------------------------------------------
  // Bus widths and word types
  // --------------------------------------------------------------------------
  localparam int CHDR_W = 128;  // Timestamp shares the header word at this width

  typedef logic [CHDR_W-1:0] chdr_word_t;
  typedef logic [4:0]        num_mdata_t;   // Metadata words following the header
  typedef logic [31:0]       err_count_t;   // Dropped packet count

  // Tag carried on each context word (tuser)
  typedef enum logic [3:0] {
    FIELD_HDR    = 4'd0,  // Header only
    FIELD_HDR_TS = 4'd1,  // Header with timestamp
    FIELD_TS     = 4'd2,  // Standalone timestamp
    FIELD_MDATA  = 4'd3   // Metadata word
  } ctxt_field_t;

  // Context FIFO entry
  typedef struct packed {
    logic        last;
    ctxt_field_t field;
    chdr_word_t  word;
  } ctxt_beat_t;

  // Payload FIFO entry, also the packet gate storage word
  typedef struct packed {
    logic       last;
    chdr_word_t word;
  } pyld_beat_t;

  // NumMData field of the CHDR header
  function automatic num_mdata_t chdr_get_num_mdata(input chdr_word_t hdr);
    return hdr[52:48];
  endfunction

endpackage

`default_nettype wire
